//--- logic/sys_pkg.sv
package sys_pkg;

    localparam int unsigned XLEN_DEFAULT = 32;
    localparam int unsigned ILEN = 32;

    typedef enum logic [3:0] {
        EXC_ILLEGAL_INSTR = 4'd2,
        EXC_BREAKPOINT    = 4'd3,  // Not raised yet
        EXC_ECALL_M       = 4'd11  // Not raised yet
    } trap_cause_t;

    typedef enum logic [1:0] {
        USER       = 2'd0,
        SUPERVISOR = 2'd1,
        MACHINE    = 2'd3
    } priv_level_t;

    localparam logic [4:0] OPC_SYSTEM = 5'b11100;  // opcode[6:2]
    localparam logic [2:0] F3_PRIV = 3'd0;
    localparam logic [2:0] F3_HLS = 3'd4;

    // funct3[1:0], funct3[2] picks the immediate form
    typedef enum logic [1:0] {
        RW = 2'd1,
        RS = 2'd2,
        RC = 2'd3
    } csr_op_t;

    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MISA = 12'h301;
    localparam logic [11:0] CSR_MTVEC = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC = 12'h341;
    localparam logic [11:0] CSR_MCAUSE = 12'h342;
    localparam logic [11:0] CSR_MHARTID = 12'hF14;

    typedef struct packed {
        logic                    valid;
        logic                    is_system;
        logic [31:0]             pc;
        logic [4:0]              rd;
        logic [4:0]              rs1;
        logic [4:0]              rs2;
        logic [2:0]              funct3;
        logic [6:0]              funct7;
        logic [11:0]             imm12;
        logic [XLEN_DEFAULT-1:0] rs1_data;
    } sys_decoded_t;

    typedef struct packed {
        logic                    valid;
        logic [11:0]             addr;
        logic [2:0]              funct3;
        logic [4:0]              rd;
        logic [4:0]              uimm;
        logic [XLEN_DEFAULT-1:0] rs1_data;
    } csr_req_t;

    typedef struct packed {
        logic                    exception;
        trap_cause_t             trap_cause;
        logic [XLEN_DEFAULT-1:0] result;
    } csr_resp_t;

    typedef struct packed {
        logic                    valid;
        logic                    exception;
        trap_cause_t             trap_cause;
        logic [XLEN_DEFAULT-1:0] result;
    } sys_result_t;

    typedef struct packed {
        logic                    valid;
        logic                    rd_we;
        logic [4:0]              rd;
        logic [XLEN_DEFAULT-1:0] rd_data;
        logic                    trap;
        trap_cause_t             trap_cause;
        logic [31:0]             trap_pc;
    } sys_wb_t;

endpackage

//--- logic/sys_decode.sv
module sys_decode #(
    parameter int unsigned XLEN = sys_pkg::XLEN_DEFAULT
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  logic [sys_pkg::ILEN-1:0] in_instr,
    input  logic [31:0]              in_pc,
    input  logic [XLEN-1:0]          in_rs1_data,
    output sys_pkg::sys_decoded_t    dec
);

    logic is_system;

    // Only full 32-bit encodings of the SYSTEM group
    assign is_system = (in_instr[6:2] == sys_pkg::OPC_SYSTEM) && (in_instr[1:0] == 2'b11);

    always_ff @(posedge clk) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        dec.is_system <= is_system;
        dec.pc        <= in_pc;
        dec.rd        <= in_instr[11:7];
        dec.funct3    <= in_instr[14:12];
        dec.rs1       <= in_instr[19:15];
        dec.rs2       <= in_instr[24:20];
        dec.funct7    <= in_instr[31:25];
        dec.imm12     <= in_instr[31:20];  // CSR address for Zicsr
        dec.rs1_data  <= in_rs1_data;
    end

endmodule

//--- logic/exec_system.sv
module exec_system #(
    parameter int unsigned XLEN = sys_pkg::XLEN_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  sys_pkg::sys_decoded_t dec,
    output sys_pkg::csr_req_t     csr_req,
    input  sys_pkg::csr_resp_t    csr_resp,
    output sys_pkg::sys_result_t  res,
    output sys_pkg::sys_decoded_t dec_q
);

    logic                 exception;
    sys_pkg::trap_cause_t trap_cause;
    logic [XLEN-1:0]      result;

    assign csr_req.valid = dec.valid && dec.is_system &&
                           dec.funct3 != sys_pkg::F3_PRIV && dec.funct3 != sys_pkg::F3_HLS;
    assign csr_req.addr = dec.imm12;
    assign csr_req.funct3 = dec.funct3;
    assign csr_req.rd = dec.rd;
    assign csr_req.uimm = dec.rs1;
    assign csr_req.rs1_data = dec.rs1_data;

    always_comb begin
        exception = 1'b0;
        trap_cause = sys_pkg::EXC_ILLEGAL_INSTR;
        result = {XLEN{1'b0}};

        if (dec.funct3 == sys_pkg::F3_HLS) begin  // Hypervisor load/store
            exception = 1'b1;
        end else if (dec.funct3 != sys_pkg::F3_PRIV) begin  // Zicsr
            exception = csr_resp.exception;
            trap_cause = csr_resp.trap_cause;
            result = csr_resp.result;
        end else if (dec.rd != 5'd0) begin
            exception = 1'b1;
        end else if (dec.funct7 == 7'b0001001) begin
            // SFENCE.VMA, nothing to flush without paging
        end else if (dec.rs1 != 5'd0) begin
            exception = 1'b1;
        end else if (dec.funct7 == 7'b0001000 && dec.rs2 == 5'd5) begin
            // WFI may complete at once
        end else begin
            exception = 1'b1;  // ECALL, EBREAK, xRET and unknown encodings
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= dec.valid && dec.is_system;
        end
        res.exception  <= exception;
        res.trap_cause <= trap_cause;
        res.result     <= result;
    end

    // Keeps rd and pc in step with res
    always_ff @(posedge clk) begin
        dec_q <= dec;
        if (rst) begin
            dec_q.valid <= 1'b0;
        end
    end

endmodule

//--- logic/csr_file.sv
module csr_file #(
    parameter int unsigned XLEN    = sys_pkg::XLEN_DEFAULT,
    parameter int unsigned HART_ID = 0
) (
    input  logic               clk,
    input  logic               rst,
    input  sys_pkg::csr_req_t  req,
    output sys_pkg::csr_resp_t resp
);

    localparam logic [XLEN-1:0] MISA_VALUE = XLEN'(32'h4000_0100);  // RV32I

    logic            mie;
    logic            mpie;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;

    sys_pkg::csr_op_t op;
    logic [XLEN-1:0]  src;
    logic [XLEN-1:0]  old_value;
    logic [XLEN-1:0]  new_value;
    logic             known;
    logic             write_intent;
    logic             illegal;
    logic             write_en;

    assign op = sys_pkg::csr_op_t'(req.funct3[1:0]);
    assign src = req.funct3[2] ? {{(XLEN-5){1'b0}}, req.uimm} : req.rs1_data;
    // Set and clear with a zero rs1 field are pure reads
    assign write_intent = req.valid && (op == sys_pkg::RW || (op != 2'd0 && req.uimm != 5'd0));

    always_comb begin
        known = 1'b1;
        old_value = {XLEN{1'b0}};
        case (req.addr)
            sys_pkg::CSR_MSTATUS: begin
                old_value[12:11] = 2'b11;  // MPP fixed at machine
                old_value[7] = mpie;
                old_value[3] = mie;
            end
            sys_pkg::CSR_MISA:     old_value = MISA_VALUE;
            sys_pkg::CSR_MTVEC:    old_value = mtvec;
            sys_pkg::CSR_MSCRATCH: old_value = mscratch;
            sys_pkg::CSR_MEPC:     old_value = mepc;
            sys_pkg::CSR_MCAUSE:   old_value = mcause;
            sys_pkg::CSR_MHARTID:  old_value = XLEN'(HART_ID);
            default:               known = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            sys_pkg::RW: new_value = src;
            sys_pkg::RS: new_value = old_value | src;
            sys_pkg::RC: new_value = old_value & ~src;
            default:     new_value = old_value;
        endcase
    end

    assign illegal = req.valid && (!known || (write_intent &&
                     (req.addr == sys_pkg::CSR_MISA || req.addr == sys_pkg::CSR_MHARTID)));
    assign write_en = write_intent && !illegal;

    assign resp.exception = illegal;
    assign resp.trap_cause = sys_pkg::EXC_ILLEGAL_INSTR;
    assign resp.result = old_value;

    always_ff @(posedge clk) begin
        if (rst) begin
            mie      <= 1'b0;
            mpie     <= 1'b0;
            mtvec    <= {XLEN{1'b0}};
            mscratch <= {XLEN{1'b0}};
            mepc     <= {XLEN{1'b0}};
            mcause   <= {XLEN{1'b0}};
        end else if (write_en) begin
            case (req.addr)
                sys_pkg::CSR_MSTATUS: begin
                    mie  <= new_value[3];
                    mpie <= new_value[7];
                end
                sys_pkg::CSR_MTVEC:    mtvec <= {new_value[XLEN-1:2], 1'b0, new_value[0]};
                sys_pkg::CSR_MSCRATCH: mscratch <= new_value;
                sys_pkg::CSR_MEPC:     mepc <= {new_value[XLEN-1:2], 2'b00};
                sys_pkg::CSR_MCAUSE:   mcause <= new_value;
                default: ;  // Read-only or unknown, never reached with write_en
            endcase
        end
    end

endmodule

//--- logic/sys_writeback.sv
module sys_writeback #(
    parameter int unsigned XLEN = sys_pkg::XLEN_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  sys_pkg::sys_result_t  res,
    input  sys_pkg::sys_decoded_t dec_q,
    output sys_pkg::sys_wb_t      wb
);

    logic rd_we;

    assign rd_we = res.valid && !res.exception && dec_q.rd != 5'd0;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid <= 1'b0;
            wb.rd_we <= 1'b0;
            wb.trap  <= 1'b0;
        end else begin
            wb.valid <= res.valid;
            wb.rd_we <= rd_we;
            wb.trap  <= res.valid && res.exception;
        end
        wb.rd         <= dec_q.rd;
        wb.rd_data    <= rd_we ? res.result : {XLEN{1'b0}};
        wb.trap_cause <= res.trap_cause;
        wb.trap_pc    <= dec_q.pc;  // Faulting instruction address
    end

endmodule

//--- logic/system_unit.sv
module system_unit #(
    parameter int unsigned XLEN    = sys_pkg::XLEN_DEFAULT,
    parameter int unsigned HART_ID = 0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  logic [sys_pkg::ILEN-1:0] in_instr,
    input  logic [31:0]              in_pc,
    input  logic [XLEN-1:0]          in_rs1_data,
    output sys_pkg::sys_wb_t         wb
);

    sys_pkg::sys_decoded_t dec;
    sys_pkg::sys_decoded_t dec_q;
    sys_pkg::csr_req_t     csr_req;
    sys_pkg::csr_resp_t    csr_resp;
    sys_pkg::sys_result_t  res;

    sys_decode #(.XLEN(XLEN)) sys_decode_inst (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_instr(in_instr),
        .in_pc(in_pc), .in_rs1_data(in_rs1_data), .dec(dec)
    );

    exec_system #(.XLEN(XLEN)) exec_system_inst (
        .clk(clk), .rst(rst), .dec(dec), .csr_req(csr_req),
        .csr_resp(csr_resp), .res(res), .dec_q(dec_q)
    );

    csr_file #(.XLEN(XLEN), .HART_ID(HART_ID)) csr_file_inst (
        .clk(clk), .rst(rst), .req(csr_req), .resp(csr_resp)
    );

    sys_writeback #(.XLEN(XLEN)) sys_writeback_inst (
        .clk(clk), .rst(rst), .res(res), .dec_q(dec_q), .wb(wb)
    );

endmodule

//--- verification/system_unit_tb.sv
module system_unit_tb;

    localparam int unsigned HART_ID = 5;

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic [31:0]      in_instr;
    logic [31:0]      in_pc;
    logic [31:0]      in_rs1_data;
    sys_pkg::sys_wb_t wb;

    string            names[$];
    logic [31:0]      instrs[$];
    logic [31:0]      pcs[$];
    logic [31:0]      rs1s[$];
    string            exp_names[$];
    sys_pkg::sys_wb_t exp_q[$];
    int               wb_count;
    integer           seed;

    // Shadow copy of the machine CSRs
    logic        sh_mie;
    logic        sh_mpie;
    logic [31:0] sh_mtvec;
    logic [31:0] sh_mscratch;
    logic [31:0] sh_mepc;

    system_unit #(.XLEN(32), .HART_ID(HART_ID)) system_unit_inst (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_instr(in_instr),
        .in_pc(in_pc), .in_rs1_data(in_rs1_data), .wb(wb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk) begin
        if (wb.valid === 1'b1) begin
            wb_count++;
        end
    end

    task automatic check(input string name, input string field,
                         input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s %s expected %h actual %h", name, field, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic logic [31:0] encode_csr(input logic [11:0] csr, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd);
        return {csr, rs1, f3, rd, 7'b1110011};
    endfunction

    // Appends one table row and predicts its write-back in program order
    task automatic add_entry(input string name, input logic [31:0] instr,
                             input logic [31:0] rs1_data);
        logic [2:0]       f3;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [11:0]      addr;
        logic [31:0]      src;
        logic [31:0]      old;
        logic [31:0]      nxt;
        logic             known;
        logic             writes;
        sys_pkg::sys_wb_t e;
        f3 = instr[14:12];
        rd = instr[11:7];
        rs1 = instr[19:15];
        addr = instr[31:20];
        e = '0;
        e.valid = 1'b1;
        e.rd = rd;
        e.trap_pc = 32'h200 + 32'(4 * names.size());
        e.trap_cause = sys_pkg::EXC_ILLEGAL_INSTR;
        names.push_back(name);
        instrs.push_back(instr);
        pcs.push_back(e.trap_pc);
        rs1s.push_back(rs1_data);
        if (instr[6:0] != 7'b1110011) return;  // Non-SYSTEM words give no write-back
        if (f3 == 3'd4) begin
            e.trap = 1'b1;
        end else if (f3 != 3'd0) begin
            src = f3[2] ? {27'd0, rs1} : rs1_data;
            writes = (f3[1:0] == 2'd1) || (rs1 != 5'd0);
            known = 1'b1;
            old = 32'd0;
            case (addr)
                12'h300: old = {19'd0, 2'b11, 3'd0, sh_mpie, 3'd0, sh_mie, 3'd0};
                12'h301: old = 32'h4000_0100;
                12'h305: old = sh_mtvec;
                12'h340: old = sh_mscratch;
                12'h341: old = sh_mepc;
                12'h342: old = 32'd0;  // mcause never written here
                12'hf14: old = 32'(HART_ID);
                default: known = 1'b0;
            endcase
            if (!known || (writes && (addr == 12'h301 || addr == 12'hf14))) begin
                e.trap = 1'b1;
            end else begin
                nxt = (f3[1:0] == 2'd1) ? src : (f3[1:0] == 2'd2) ? (old | src) : (old & ~src);
                if (writes) begin
                    case (addr)
                        12'h300: begin
                            sh_mie = nxt[3];
                            sh_mpie = nxt[7];
                        end
                        12'h305: sh_mtvec = nxt & ~32'h2;
                        12'h340: sh_mscratch = nxt;
                        12'h341: sh_mepc = nxt & ~32'h3;
                        default: ;
                    endcase
                end
                e.rd_we = (rd != 5'd0);
                e.rd_data = e.rd_we ? old : 32'd0;
            end
        end else begin
            // Only SFENCE.VMA with rd 0 and the plain WFI word pass
            e.trap = !((rd == 5'd0 && instr[31:25] == 7'b0001001) || instr == 32'h1050_0073);
        end
        exp_q.push_back(e);
        exp_names.push_back(name);
    endtask

    task automatic build_table();
        add_entry("csrrw_mscratch", encode_csr(12'h340, 5'd5, 3'd1, 5'd1), $random(seed));
        add_entry("mscratch_read", encode_csr(12'h340, 5'd0, 3'd2, 5'd2), 32'hffff_ffff);
        add_entry("addi_dropped", 32'h0010_0093, 32'd0);
        add_entry("csrrw_mscratch_rd0", encode_csr(12'h340, 5'd6, 3'd1, 5'd0), $random(seed));
        add_entry("mscratch_read_2", encode_csr(12'h340, 5'd0, 3'd2, 5'd3), 32'd0);
        add_entry("csrrs_mstatus", encode_csr(12'h300, 5'd7, 3'd2, 5'd4), $random(seed));
        add_entry("csrrc_mstatus", encode_csr(12'h300, 5'd8, 3'd3, 5'd5), $random(seed));
        add_entry("mstatus_read", encode_csr(12'h300, 5'd0, 3'd2, 5'd6), 32'd0);
        add_entry("csrrwi_mtvec", encode_csr(12'h305, 5'd31, 3'd5, 5'd7), 32'd0);
        add_entry("csrrsi_mtvec_read", encode_csr(12'h305, 5'd0, 3'd6, 5'd8), 32'd0);
        add_entry("csrrw_mtvec", encode_csr(12'h305, 5'd9, 3'd1, 5'd9), $random(seed));
        add_entry("lw_dropped", 32'h0000_a103, 32'd0);
        add_entry("csrrwi_mepc", encode_csr(12'h341, 5'd31, 3'd5, 5'd10), 32'd0);
        add_entry("csrrci_mepc", encode_csr(12'h341, 5'd8, 3'd7, 5'd11), 32'd0);
        add_entry("csrrw_mepc", encode_csr(12'h341, 5'd1, 3'd1, 5'd12), $random(seed));
        add_entry("mepc_read", encode_csr(12'h341, 5'd0, 3'd2, 5'd13), 32'd0);
        add_entry("misa_read", encode_csr(12'h301, 5'd0, 3'd2, 5'd14), 32'd0);
        add_entry("mhartid_read", encode_csr(12'hf14, 5'd0, 3'd2, 5'd15), 32'd0);
        add_entry("csrrw_misa", encode_csr(12'h301, 5'd2, 3'd1, 5'd16), $random(seed));
        add_entry("misa_after_write", encode_csr(12'h301, 5'd0, 3'd2, 5'd17), 32'd0);
        add_entry("csrrsi_mhartid", encode_csr(12'hf14, 5'd1, 3'd6, 5'd18), 32'd0);
        add_entry("unknown_csr", encode_csr(12'h7c0, 5'd0, 3'd2, 5'd19), 32'd0);
        add_entry("ecall", 32'h0000_0073, 32'd0);
        add_entry("ebreak", 32'h0010_0073, 32'd0);
        add_entry("mret", 32'h3020_0073, 32'd0);
        add_entry("sret", 32'h1020_0073, 32'd0);
        add_entry("hlv", 32'h6000_c0f3, 32'd0);
        add_entry("priv_rd_nonzero", 32'h1050_00f3, 32'd0);
        add_entry("priv_rs1_nonzero", 32'h1050_8073, 32'd0);
        add_entry("wfi", 32'h1050_0073, 32'd0);
        add_entry("sfence_vma", 32'h1200_0073, 32'd0);
        add_entry("sfence_vma_regs", 32'h1220_8073, 32'd0);
    endtask

    task automatic drive_entries();
        int i;
        for (i = 0; i < names.size(); i++) begin
            in_valid = 1'b1;
            in_instr = instrs[i];
            in_pc = pcs[i];
            in_rs1_data = rs1s[i];
            @(negedge clk);
        end
        in_valid = 1'b0;
        in_instr = 32'd0;
    endtask

    task automatic collect_results();
        int               k;
        int               waited;
        sys_pkg::sys_wb_t e;
        for (k = 0; k < exp_q.size(); k++) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
                if (wb.valid !== 1'b1 && waited >= 20) begin
                    $display("ERROR: write-back for %s never came", exp_names[k]);
                    $display("CHECKS FAILED");
                    $fatal(1, "timeout while waiting for a write-back");
                end
            end while (wb.valid !== 1'b1);
            e = exp_q[k];
            check(exp_names[k], "rd_we", 32'(e.rd_we), 32'(wb.rd_we));
            check(exp_names[k], "trap", 32'(e.trap), 32'(wb.trap));
            check(exp_names[k], "rd", 32'(e.rd), 32'(wb.rd));
            check(exp_names[k], "rd_data", e.rd_data, wb.rd_data);
            if (e.trap) begin
                check(exp_names[k], "trap_cause", 32'(e.trap_cause), 32'(wb.trap_cause));
                check(exp_names[k], "trap_pc", e.trap_pc, wb.trap_pc);
            end
        end
    endtask

    initial begin
        seed = 32'hb6a11832;
        rst = 1'b1;
        in_valid = 1'b0;
        in_instr = 32'd0;
        in_pc = 32'd0;
        in_rs1_data = 32'd0;
        wb_count = 0;
        sh_mie = 1'b0;
        sh_mpie = 1'b0;
        sh_mtvec = 32'd0;
        sh_mscratch = 32'd0;
        sh_mepc = 32'd0;
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fork
            drive_entries();
            collect_results();
        join
        repeat (6) @(negedge clk);  // Room for any stray write-back
        check("end_of_run", "write-back count", 32'(exp_q.size()), 32'(wb_count));
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- files.f
logic/sys_pkg.sv
logic/sys_decode.sv
logic/exec_system.sv
logic/csr_file.sv
logic/sys_writeback.sv
logic/system_unit.sv
verification/system_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= system_unit_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SRCS := $(shell grep -v '^+' $(FILE_LIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(SIM): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)

check: run
	@if grep -qx 'ALL CHECKS PASSED' $(LOG); then echo "simulation passed"; \
	else echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
